//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0 -Mdir obj_dir
TOP       = tb_samc_core
FILELIST  = files.f

.PHONY: sim clean

# Build, run, and fail unless the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

//--- files.f
+incdir+sim
src/samc_bus_pkg.sv
src/samc_clock_pkg.sv
src/ce_timer.sv
src/speed_fsm.sv
src/asic_ports.sv
src/mem_mapper.sv
src/samc_core.sv
sim/tb_samc_core.sv

//--- sim/samc_model.svh
//======================================
// Reference model of the ASIC paging
// registers and the CPU address map,
// included inside the testbench module
//======================================

`ifndef SAMC_MODEL_SVH
`define SAMC_MODEL_SVH

// Model copies of the port registers
logic [7:0] m_lmpr;
logic [7:0] m_hmpr;
logic [7:0] m_ext_c;
logic [7:0] m_ext_d;
logic [7:0] m_brdr;

function automatic void clear_registers();
	m_lmpr  = '0;
	m_hmpr  = '0;
	m_ext_c = '0;
	m_ext_d = '0;
	m_brdr  = '0;
endfunction

// Port numbers 128, 129, 250, 251 and 254
function automatic void store_port(input logic [7:0] port, input logic [7:0] data);
	case (port)
		8'd128: m_ext_c = data;
		8'd129: m_ext_d = data;
		8'd250: m_lmpr  = data;
		8'd251: m_hmpr  = data;
		8'd254: m_brdr  = data;
		default: ;
	endcase
endfunction

// Only LMPR and HMPR read back
function automatic logic [7:0] load_port(input logic [7:0] port);
	if (port == 8'd250)
		return m_lmpr;
	if (port == 8'd251)
		return m_hmpr;
	return 8'hFF;
endfunction

function automatic mem_req_t map_address(input logic [15:0] addr, input logic mreq,
		input logic wr);
	logic [1:0] sect;
	logic       rom;
	logic [8:0] page;
	mem_req_t   r;
	sect = addr[15:14];
	rom  = (!m_lmpr[5] && sect == 2'd0) || (m_lmpr[6] && sect == 2'd3);
	if (m_hmpr[7] && addr[15])
		page = 9'h40 + {1'b0, (addr[14] ? m_ext_d : m_ext_c)};
	else begin
		case (sect)
			2'd0:    page = {4'd0, m_lmpr[4:0]};
			2'd1:    page = {4'd0, m_lmpr[4:0] + 5'd1};
			2'd2:    page = {4'd0, m_hmpr[4:0]};
			default: page = {4'd0, m_hmpr[4:0] + 5'd1};
		endcase
	end
	r.rom_sel = rom;
	r.addr    = rom ? {3'b000, 5'h10, addr[15], addr[13:0]} : {page, addr[13:0]};
	r.we      = mreq && wr && !rom && !(m_lmpr[7] && sect == 2'd0);
	return r;
endfunction

`endif

//--- sim/tb_samc_core.sv
//======================================
// Testbench for the memory and timing
// core: random port writes and memory
// accesses against a model, then speed
//======================================

`timescale 1ns/10ps

module tb_samc_core import samc_bus_pkg::*; ();

	localparam int RESET_CYCLES = 4;
	localparam int N_PORT       = 200;
	localparam int N_SETUP      = 40;
	localparam int N_ACCESS     = 8;
	localparam int N_PULSES     = 10;
	localparam int SWITCH_MAX   = 128;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + 8 + N_PORT * 6 + N_SETUP * (8 + N_ACCESS)
		+ (N_PULSES + 2) * (2 * 16 + 27) + 2 * SWITCH_MAX + 200;

	logic        clk_sys;
	logic        reset;
	cpu_bus_t    bus;
	logic        zx_request;
	mem_req_t    mem;
	logic [7:0]  port_dout;
	logic [3:0]  border_color;
	logic        ear_out;
	logic        ce_cpu_p;
	logic        ce_cpu_n;
	logic        zx_active;
	logic [31:0] lfsr_state;
	int          cycle;
	int          checks;
	int          errors;
	int          tests;

	`include "samc_model.svh"

	samc_core uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.zx_request   (zx_request),
		.mem          (mem),
		.port_dout    (port_dout),
		.border_color (border_color),
		.ear_out      (ear_out),
		.ce_cpu_p     (ce_cpu_p),
		.ce_cpu_n     (ce_cpu_n),
		.zx_active    (zx_active)
	);

	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the tests did not complete", cycle);
			$display("=== FAIL ===");
			$finish;
		end
	end

	//======================================
	// Random numbers
	//======================================

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out        = lfsr_state[0];
		lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	//======================================
	// Bus and check tasks
	//======================================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// Data changes while the strobe is held, only the first value counts
	task automatic write_port(input logic [15:0] addr, input logic [7:0] data, input int hold);
		cpu_bus_t b;
		int       i;
		b      = '0;
		b.addr = addr;
		b.data = data;
		b.iorq = 1'b1;
		b.wr   = 1'b1;
		store_port(addr[7:0], data);
		@(posedge clk_sys);
		bus <= b;
		for (i = 1; i < hold; i++) begin
			b.data = b.data + 8'd1;
			@(posedge clk_sys);
			bus <= b;
		end
		@(posedge clk_sys);
		bus <= '0;
	endtask

	task automatic read_port(input logic [15:0] addr);
		cpu_bus_t b;
		b      = '0;
		b.addr = addr;
		b.iorq = 1'b1;
		b.rd   = 1'b1;
		@(posedge clk_sys);
		bus <= b;
		@(negedge clk_sys);
		check_value("port_dout", 32'(port_dout), 32'(load_port(addr[7:0])));
	endtask

	task automatic access_memory(input logic [15:0] addr, input logic mreq, input logic wr);
		cpu_bus_t b;
		mem_req_t exp;
		b      = '0;
		b.addr = addr;
		b.data = 8'(rand_bits(8));
		b.mreq = mreq;
		b.wr   = wr;
		b.rd   = ~wr;
		exp    = map_address(addr, mreq, wr);
		@(posedge clk_sys);
		bus <= b;
		@(negedge clk_sys);
		check_value("mem.addr", 32'(mem.addr), 32'(exp.addr));
		check_value("mem.we", 32'(mem.we), 32'(exp.we));
		check_value("mem.rom_sel", 32'(mem.rom_sel), 32'(exp.rom_sel));
	endtask

	// Spacing of ce_cpu_p, and ce_cpu_n after each one
	task automatic measure_pulses(input int period, input int half);
		int last_p;
		int seen;
		int got_n;
		last_p = -1;
		seen   = 0;
		got_n  = 0;
		while (seen < N_PULSES) begin
			@(negedge clk_sys);
			if (ce_cpu_n && last_p >= 0) begin
				check_value("ce_cpu_n delay", 32'(cycle - last_p), 32'(half));
				got_n = 1;
			end
			if (ce_cpu_p) begin
				if (last_p >= 0) begin
					check_value("ce_cpu_p period", 32'(cycle - last_p), 32'(period));
					checks++;
					assert (got_n == 1) else begin
						errors++;
						$display("No ce_cpu_n between two ce_cpu_p pulses at %0t ns", $time);
					end
					seen++;
				end
				last_p = cycle;
				got_n  = 0;
			end
		end
	endtask

	task automatic wait_speed_switch(input logic target);
		while (zx_active !== target) begin
			@(negedge clk_sys);
			checks++;
			assert (!(ce_cpu_p || ce_cpu_n) || zx_active == zx_request) else begin
				errors++;
				$display("CPU enable pulse at %0t ns while the speed switch was running", $time);
			end
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests++;
		$display("Test %0d %s: %0d errors", tests, name, errors - err_start);
	endtask

	//======================================
	// Test sequence
	//======================================

	initial begin
		logic [15:0] addr;
		logic [7:0]  lo;
		logic [2:0]  sel;
		int          i;
		int          j;
		int          err_start;
		clk_sys    = 1'b0;
		reset      = 1'b1;
		bus        = '0;
		zx_request = 1'b0;
		lfsr_state = 32'h1750_a02c;
		cycle      = 0;
		checks     = 0;
		errors     = 0;
		tests      = 0;
		clear_registers();

		// Reset
		err_start = errors;
		for (i = 0; i < RESET_CYCLES - 1; i++) begin
			@(negedge clk_sys);
			check_value("ce_cpu_p", 32'(ce_cpu_p), 32'd0);
			check_value("zx_active", 32'(zx_active), 32'd0);
		end
		@(posedge clk_sys);
		reset <= 1'b0;
		read_port(16'h00FA);
		read_port(16'h00FB);
		check_value("zx_active", 32'(zx_active), 32'd0);
		end_test("reset", err_start);

		// Port writes with random hold lengths
		err_start = errors;
		for (i = 0; i < N_PORT; i++) begin
			sel = 3'(rand_bits(3));
			case (sel)
				3'd0:    lo = 8'd128;
				3'd1:    lo = 8'd129;
				3'd2:    lo = 8'd250;
				3'd3:    lo = 8'd251;
				3'd4:    lo = 8'd254;
				default: lo = 8'(rand_bits(8));
			endcase
			addr = {8'(rand_bits(8)), lo};
			write_port(addr, 8'(rand_bits(8)), int'(rand_bits(2)) + 1);
			read_port(addr);
			check_value("border_color", 32'(border_color), 32'({m_brdr[5], m_brdr[2:0]}));
			check_value("ear_out", 32'(ear_out), 32'(m_brdr[4]));
		end
		end_test("port registers", err_start);

		// Paging setups followed by memory accesses
		err_start = errors;
		for (i = 0; i < N_SETUP; i++) begin
			write_port({8'(rand_bits(8)), 8'd250}, 8'(rand_bits(8)), 1);
			write_port({8'(rand_bits(8)), 8'd251}, 8'(rand_bits(8)), 1);
			write_port({8'(rand_bits(8)), 8'd128}, 8'(rand_bits(8)), 1);
			write_port({8'(rand_bits(8)), 8'd129}, 8'(rand_bits(8)), 1);
			for (j = 0; j < N_ACCESS; j++)
				access_memory(16'(rand_bits(16)), lfsr_bit(), lfsr_bit());
		end
		end_test("address map", err_start);

		err_start = errors;
		measure_pulses(16, 8);
		end_test("native speed", err_start);

		err_start = errors;
		@(posedge clk_sys);
		zx_request <= 1'b1;
		wait_speed_switch(1'b1);
		measure_pulses(27, 13);
		@(posedge clk_sys);
		zx_request <= 1'b0;
		wait_speed_switch(1'b0);
		measure_pulses(16, 8);
		end_test("speed switch", err_start);

		$display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- src/asic_ports.sv
//======================================
// ASIC paging, border and external RAM
// page registers with their read path
//======================================

`timescale 1ns/10ps

module asic_ports import samc_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	output paging_t    paging,
	output logic [3:0] border_color,
	output logic       ear_out,
	output logic [7:0] port_dout
);

	port_id_e   port_id;
	logic       port_we;
	logic       port_rd;
	logic       port_we_d;
	logic       we_edge;
	logic [7:0] brdr;

	//======================================
	// Decode
	//======================================

	always_comb begin
		case (bus.addr[7:0])
			PORT_ADDR_EXTC: port_id = PORT_EXTC;
			PORT_ADDR_EXTD: port_id = PORT_EXTD;
			PORT_ADDR_LMPR: port_id = PORT_LMPR;
			PORT_ADDR_HMPR: port_id = PORT_HMPR;
			PORT_ADDR_BRDR: port_id = PORT_BRDR;
			default:        port_id = PORT_NONE;
		endcase
	end

	// Interrupt acknowledge cycles carry m1 and are ignored
	assign port_we = bus.iorq & bus.wr & ~bus.m1;
	assign port_rd = bus.iorq & bus.rd & ~bus.m1;
	assign we_edge = port_we & ~port_we_d;

	//======================================
	// Registers
	//======================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port_we_d <= 1'b0;
			paging    <= '0;
			brdr      <= '0;
		end else begin
			port_we_d <= port_we;
			// One write per strobe, however long it is held
			if (we_edge) begin
				case (port_id)
					PORT_EXTC: paging.ext_c <= bus.data;
					PORT_EXTD: paging.ext_d <= bus.data;
					PORT_LMPR: paging.lmpr  <= bus.data;
					PORT_HMPR: paging.hmpr  <= bus.data;
					PORT_BRDR: brdr         <= bus.data;
					default: ;
				endcase
			end
		end
	end

	// Colour is bits 5 and 2..0, EAR is bit 4
	assign border_color = {brdr[5], brdr[2:0]};
	assign ear_out      = brdr[4];

	always_comb begin
		port_dout = 8'hFF;
		if (port_rd) begin
			case (port_id)
				PORT_LMPR: port_dout = paging.lmpr;
				PORT_HMPR: port_dout = paging.hmpr;
				default:   port_dout = 8'hFF;
			endcase
		end
	end

endmodule

//--- src/ce_timer.sv
//======================================
// Free running native and ZX dividers
// with registered phase pulses
//======================================

`timescale 1ns/10ps

module ce_timer import samc_clock_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	output logic orig_tick,
	output logic orig_half,
	output logic zx_tick,
	output logic zx_half,
	output logic zx_phase1,
	output logic orig_phase1
);

	logic [3:0] orig_cnt;
	logic [4:0] zx_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			orig_cnt    <= '0;
			zx_cnt      <= '0;
			orig_tick   <= 1'b0;
			orig_half   <= 1'b0;
			orig_phase1 <= 1'b0;
			zx_tick     <= 1'b0;
			zx_half     <= 1'b0;
			zx_phase1   <= 1'b0;
		end else begin
			if (orig_cnt == 4'(ORIG_DIV - 1))
				orig_cnt <= '0;
			else
				orig_cnt <= orig_cnt + 4'd1;

			if (zx_cnt == 5'(ZX_DIV - 1))
				zx_cnt <= '0;
			else
				zx_cnt <= zx_cnt + 5'd1;

			// Pulses trail the counter value by one cycle
			orig_tick   <= (orig_cnt == 4'd0);
			orig_half   <= (orig_cnt == 4'(ORIG_N_PHASE));
			orig_phase1 <= (orig_cnt == 4'd1);
			zx_tick     <= (zx_cnt == 5'd0);
			zx_half     <= (zx_cnt == 5'(ZX_N_PHASE));
			zx_phase1   <= (zx_cnt == 5'd1);
		end
	end

endmodule

//--- src/mem_mapper.sv
//======================================
// Maps a CPU address onto the RAM and
// ROM space from the paging registers
//======================================

`timescale 1ns/10ps

module mem_mapper import samc_bus_pkg::*; (
	input  cpu_bus_t bus,
	input  paging_t  paging,
	output mem_req_t mem
);

	logic [1:0]         section;
	logic [PAGE_W-1:0]  offset;
	logic               rom0_sel;
	logic               rom1_sel;
	logic               ram_wp;
	logic               ext_ram;
	logic [PAGE_NW-1:0] page;

	assign section = bus.addr[15:14];
	assign offset  = bus.addr[PAGE_W-1:0];

	assign rom0_sel = ~paging.lmpr[5] & (section == 2'd0);
	assign rom1_sel = paging.lmpr[6] & (section == 2'd3);
	// Section A write protect
	assign ram_wp   = paging.lmpr[7] & (section == 2'd0);
	assign ext_ram  = paging.hmpr[7] & bus.addr[15];

	// Page numbers wrap within the 5-bit internal field
	always_comb begin
		if (ext_ram) begin
			page = bus.addr[14] ? EXT_BASE + {1'b0, paging.ext_d}
			                    : EXT_BASE + {1'b0, paging.ext_c};
		end else begin
			case (section)
				2'd0:    page = {4'd0, paging.lmpr[4:0]};
				2'd1:    page = {4'd0, paging.lmpr[4:0] + 5'd1};
				2'd2:    page = {4'd0, paging.hmpr[4:0]};
				default: page = {4'd0, paging.hmpr[4:0] + 5'd1};
			endcase
		end
	end

	always_comb begin
		mem.rom_sel = rom0_sel | rom1_sel;
		if (mem.rom_sel)
			mem.addr = RAM_AW'({ROM_BASE, bus.addr[15], offset});
		else
			mem.addr = {page, offset};
		mem.we = bus.mreq & bus.wr & ~mem.rom_sel & ~ram_wp;
	end

endmodule

//--- src/samc_bus_pkg.sv
//======================================
// CPU bus, memory map and port decode
// definitions shared by the port block,
// the address mapper and the top level
//======================================

package samc_bus_pkg;

	// RAM address is a 9-bit page above a 14-bit offset
	localparam int RAM_AW  = 23;
	localparam int PAGE_W  = 14;
	localparam int PAGE_NW = RAM_AW - PAGE_W;

	// First page of external RAM
	localparam logic [8:0] EXT_BASE = 9'h40;
	// ROM pages sit above internal RAM
	localparam logic [4:0] ROM_BASE = 5'h10;

	// ASIC port numbers on addr[7:0]
	localparam logic [7:0] PORT_ADDR_EXTC = 8'd128;
	localparam logic [7:0] PORT_ADDR_EXTD = 8'd129;
	localparam logic [7:0] PORT_ADDR_LMPR = 8'd250;
	localparam logic [7:0] PORT_ADDR_HMPR = 8'd251;
	localparam logic [7:0] PORT_ADDR_BRDR = 8'd254;

	typedef enum logic [2:0] {
		PORT_NONE,
		PORT_EXTC,
		PORT_EXTD,
		PORT_LMPR,
		PORT_HMPR,
		PORT_BRDR
	} port_id_e;

	// One Z80 bus cycle, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic              we;
		logic              rom_sel;
	} mem_req_t;

	// Paging state handed from the ports to the mapper
	typedef struct packed {
		logic [7:0] lmpr;
		logic [7:0] hmpr;
		logic [7:0] ext_c;
		logic [7:0] ext_d;
	} paging_t;

endpackage

//--- src/samc_clock_pkg.sv
//======================================
// CPU clock enable and speed switch
// constants for the timer and the FSM
//======================================

package samc_clock_pkg;

	// Native cycle and its negative-edge phase
	localparam int ORIG_DIV     = 16;
	localparam int ORIG_N_PHASE = ORIG_DIV / 2;

	// ZX Spectrum speed cycle
	localparam int ZX_DIV     = 27;
	localparam int ZX_N_PHASE = 13;

	// ZX periods spent stopped before the new speed starts
	localparam logic [1:0] SWITCH_TIMEOUT = 2'd3;

	typedef enum logic [1:0] {
		ST_ORIG,
		ST_ZX,
		ST_STOP,
		ST_WAIT
	} speed_state_e;

endpackage

//--- src/samc_core.sv
//======================================
// Memory and timing core: CPU enables,
// ASIC ports and the address mapper
//======================================

`timescale 1ns/10ps

module samc_core import samc_bus_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  cpu_bus_t   bus,
	input  logic       zx_request,
	output mem_req_t   mem,
	output logic [7:0] port_dout,
	output logic [3:0] border_color,
	output logic       ear_out,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n,
	output logic       zx_active
);

	logic    orig_tick;
	logic    orig_half;
	logic    orig_phase1;
	logic    zx_tick;
	logic    zx_half;
	logic    zx_phase1;
	paging_t paging;

	ce_timer timer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.orig_tick   (orig_tick),
		.orig_half   (orig_half),
		.zx_tick     (zx_tick),
		.zx_half     (zx_half),
		.zx_phase1   (zx_phase1),
		.orig_phase1 (orig_phase1)
	);

	speed_fsm speed (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.zx_request  (zx_request),
		.orig_tick   (orig_tick),
		.orig_half   (orig_half),
		.zx_tick     (zx_tick),
		.zx_half     (zx_half),
		.zx_phase1   (zx_phase1),
		.orig_phase1 (orig_phase1),
		.ce_cpu_p    (ce_cpu_p),
		.ce_cpu_n    (ce_cpu_n),
		.zx_active   (zx_active)
	);

	asic_ports ports (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus          (bus),
		.paging       (paging),
		.border_color (border_color),
		.ear_out      (ear_out),
		.port_dout    (port_dout)
	);

	mem_mapper mapper (
		.bus    (bus),
		.paging (paging),
		.mem    (mem)
	);

endmodule

//--- src/speed_fsm.sv
//======================================
// Switches the CPU enables between the
// native and the ZX divider, stopping
// the CPU for a short timeout between
//======================================

`timescale 1ns/10ps

module speed_fsm import samc_clock_pkg::*; (
	input  logic clk_sys,
	input  logic reset,
	input  logic zx_request,
	input  logic orig_tick,
	input  logic orig_half,
	input  logic zx_tick,
	input  logic zx_half,
	input  logic zx_phase1,
	input  logic orig_phase1,
	output logic ce_cpu_p,
	output logic ce_cpu_n,
	output logic zx_active
);

	speed_state_e state;
	logic [1:0]   timeout;
	// Divider that was running when the switch began
	logic         src_zx;
	logic         stop_point;
	logic         run_orig;
	logic         run_zx;

	// A pending request silences the old speed at once
	assign run_orig = (state == ST_ORIG) & ~zx_request;
	assign run_zx   = (state == ST_ZX) & zx_request;

	assign stop_point = src_zx ? zx_phase1 : orig_phase1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= ST_ORIG;
			timeout <= '0;
			src_zx  <= 1'b0;
		end else begin
			case (state)
				ST_ORIG: begin
					if (zx_request) begin
						state  <= ST_STOP;
						src_zx <= 1'b0;
					end
				end
				ST_ZX: begin
					if (!zx_request) begin
						state  <= ST_STOP;
						src_zx <= 1'b1;
					end
				end
				// Halt on a clean divider boundary
				ST_STOP: begin
					if (stop_point) begin
						state   <= ST_WAIT;
						timeout <= SWITCH_TIMEOUT;
					end
				end
				// Count ZX periods, then take the requested speed
				ST_WAIT: begin
					if (zx_phase1) begin
						if (timeout == 2'd1)
							state <= zx_request ? ST_ZX : ST_ORIG;
						else
							timeout <= timeout - 2'd1;
					end
				end
				default: state <= ST_ORIG;
			endcase
		end
	end

	assign ce_cpu_p  = (run_orig & orig_tick) | (run_zx & zx_tick);
	assign ce_cpu_n  = (run_orig & orig_half) | (run_zx & zx_half);
	assign zx_active = (state == ST_ZX);

endmodule
